/* sources.f */
common/mesh_setup_pkg.sv
rtl/route_select.sv
rtl/route_commit.sv
rtl/mesh_setup_master.sv
verif/tb_mesh_setup_master.sv

/* Makefile */
# Verilator simulation of the mesh setup master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_mesh_setup_master \
		-Mdir obj_dir -o sim_mesh
	./obj_dir/sim_mesh | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_mesh_setup_master.sv */
//####################################################################
// testbench for the mesh setup master
// ring-walk reference model, merge in processor order, and checks
// of router controls, grants and path block signals
//####################################################################

`timescale 1ns/100ps
`default_nettype none

module tb_mesh_setup_master
    import mesh_setup_pkg::*;
();

    typedef router_ctrl_u [num_nodes-1:0] mesh_ctrl_t;

    localparam int clock_period  = 10;
    localparam int reset_cycles  = 10;
    localparam int random_cycles = 200;  // longest test
    localparam int num_tests     = 6;
    localparam int watchdog_time = num_tests * random_cycles * clock_period + 1000;

    // clockwise order around the mesh
    localparam int ring_cw [num_nodes] = '{0, 2, 3, 1};

    logic                         clock;
    logic                         reset;
    logic [num_paths-1:0]         path_free;
    logic [num_nodes-1:0]         request;
    node_id_t [num_nodes-1:0]     request_dest;
    router_ctrl_u [num_nodes-1:0] router_ctrl;
    logic [num_nodes-1:0]         response;
    logic [num_nodes*num_dirs-1:0] path_block;

    mesh_ctrl_t           held_ctrl;  // model of the registered controls
    mesh_ctrl_t           exp_prop [num_nodes];
    logic [num_nodes-1:0] exp_grant;

    string test_name;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_run;

    mesh_setup_master uut (
        .clock        (clock),
        .reset        (reset),
        .path_free    (path_free),
        .request      (request),
        .request_dest (request_dest),
        .router_ctrl  (router_ctrl),
        .response     (response),
        .path_block   (path_block)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic int ring_step(input int n, input logic cw);
        int pos;
        pos = 0;
        for (int i = 0; i < num_nodes; i++)
        begin
            if (ring_cw[i] == n)
            begin
                pos = i;
            end
        end
        if (cw)
        begin
            return ring_cw[(pos + 1) % num_nodes];
        end
        return ring_cw[(pos + num_nodes - 1) % num_nodes];
    endfunction

    // x is bit 0 and y is bit 1 of the node number
    function automatic logic [2:0] edge_toward(input int from_node, input int to_node);
        int         dx;
        int         dy;
        logic [2:0] result;
        dx = (to_node % 2) - (from_node % 2);
        dy = (to_node / 2) - (from_node / 2);
        if (dx > 0)
        begin
            result = dir_east;
        end
        else if (dx < 0)
        begin
            result = dir_west;
        end
        else if (dy > 0)
        begin
            result = dir_north;
        end
        else
        begin
            result = dir_south;
        end
        return result;
    endfunction

    function automatic logic [sel_width-1:0] sel_of_edge(input logic [2:0] e);
        logic [sel_width-1:0] result;
        case (e)
            dir_north: result = sel_from_north;
            dir_south: result = sel_from_south;
            dir_east:  result = sel_from_east;
            dir_west:  result = sel_from_west;
            default:   result = sel_from_proc;
        endcase
        return result;
    endfunction

    function automatic mesh_ctrl_t mark_edge(input mesh_ctrl_t m, input int r,
                                             input logic [2:0] e,
                                             input logic [sel_width-1:0] s);
        mesh_ctrl_t result;
        result = m;
        result[r].fields.sel[e] = s;
        result[r].fields.en[e]  = 1'b1;
        return result;
    endfunction

    // self is slot 0, then two slots per other node in ascending order
    function automatic int route_slot(input int src, input int dst);
        int slot;
        slot = 1;
        for (int n = 0; n < num_nodes; n++)
        begin
            if (n != src && n < dst)
            begin
                slot += 2;
            end
        end
        return slot;
    endfunction

    // expected proposal of one source, returns its grant
    function automatic logic model_route(input int src, input int dst, input logic req,
                                         input logic [paths_per_node-1:0] free,
                                         output mesh_ctrl_t prop);
        int   slot;
        int   cur;
        int   prev;
        int   nxt;
        logic primary_cw;
        logic walk_cw;
        logic found;
        prop    = '0;
        found   = 1'b0;
        walk_cw = 1'b0;
        if (req && dst == src)
        begin
            found = free[0];
            if (found)
            begin
                prop = mark_edge(prop, src, dir_proc, sel_from_proc);
            end
        end
        else if (req)
        begin
            if (dst == ring_step(src, 1'b1))
            begin
                primary_cw = 1'b1;
            end
            else if (dst == ring_step(src, 1'b0))
            begin
                primary_cw = 1'b0;
            end
            else
            begin
                primary_cw = (src % 2 == 0);  // even sources go clockwise
            end
            slot = route_slot(src, dst);
            if (free[slot])
            begin
                found   = 1'b1;
                walk_cw = primary_cw;
            end
            else if (free[slot + 1])
            begin
                found   = 1'b1;
                walk_cw = !primary_cw;
            end
            if (found)
            begin
                cur  = src;
                nxt  = ring_step(cur, walk_cw);
                prop = mark_edge(prop, cur, edge_toward(cur, nxt), sel_from_proc);
                while (nxt != dst)
                begin
                    prev = cur;
                    cur  = nxt;
                    nxt  = ring_step(cur, walk_cw);
                    prop = mark_edge(prop, cur, edge_toward(cur, nxt),
                                     sel_of_edge(edge_toward(cur, prev)));
                end
                prop = mark_edge(prop, dst, dir_proc, sel_of_edge(edge_toward(dst, cur)));
            end
        end
        return found;
    endfunction

    task automatic check_value(input string what, input logic [79:0] expected,
                               input logic [79:0] actual);
        test_checks++;
        assert (actual === expected)
        else
        begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_idle();
        check_value("router_ctrl", '0, router_ctrl);
        check_value("response", '0, 80'(response));
        check_value("path_block", 80'({(num_nodes*num_dirs){1'b1}}), 80'(path_block));
    endtask

    // one request cycle, path_block checked ahead of the edge
    task automatic run_cycle(input logic [num_nodes-1:0] req,
                             input logic [2*num_nodes-1:0] dst,
                             input logic [num_paths-1:0] free);
        mesh_ctrl_t                    next_ctrl;
        logic [num_nodes*num_dirs-1:0] exp_block;
        @(negedge clock);
        request      = req;
        request_dest = dst;
        path_free    = free;
        for (int p = 0; p < num_nodes; p++)
        begin
            exp_grant[p] = model_route(p, int'(dst[2*p +: 2]), req[p],
                                       free[p*paths_per_node +: paths_per_node], exp_prop[p]);
        end
        next_ctrl = held_ctrl;
        for (int r = 0; r < num_nodes; r++)
        begin
            next_ctrl[r].fields.en = '0;
        end
        for (int p = 0; p < num_nodes; p++)
        begin
            for (int r = 0; r < num_nodes; r++)
            begin
                for (int d = 0; d < num_dirs; d++)
                begin
                    if (exp_prop[p][r].fields.en[d])
                    begin
                        next_ctrl[r].fields.sel[d] = exp_prop[p][r].fields.sel[d];
                        next_ctrl[r].fields.en[d]  = 1'b1;
                    end
                end
            end
        end
        for (int r = 0; r < num_nodes; r++)
        begin
            exp_block[r*num_dirs +: num_dirs] = ~next_ctrl[r].fields.en;
        end
        #2;
        check_value("path_block", 80'(exp_block), 80'(path_block));
        @(posedge clock);
        #1;
        check_value("router_ctrl", next_ctrl, router_ctrl);
        check_value("response", 80'(exp_grant), 80'(response));
        held_ctrl = next_ctrl;
    endtask

    // primary free, alternate only, then no route
    task automatic test_route_cases(input int src, input int dst);
        logic [num_paths-1:0]   free;
        logic [2*num_nodes-1:0] dests;
        logic [num_nodes-1:0]   req;
        int                     bit_pos;
        bit_pos = src * paths_per_node + route_slot(src, dst);
        req = '0;
        req[src] = 1'b1;
        dests = '0;
        dests[2*src +: 2] = 2'(dst);
        free = '1;
        run_cycle(req, dests, free);
        free[bit_pos] = 1'b0;
        run_cycle(req, dests, free);
        free[bit_pos + 1] = 1'b0;
        run_cycle(req, dests, free);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
    endtask

    initial
    begin
        #(watchdog_time);
        $display("timeout: run did not finish within %0d ns", watchdog_time);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        logic [num_paths-1:0]   free;
        logic [2*num_nodes-1:0] dests;
        void'($urandom(32'hb132));
        clock        = 1'b0;
        reset        = 1'b1;
        request      = '0;
        request_dest = '0;
        path_free    = '0;
        held_ctrl    = '0;
        exp_grant    = '0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;

        begin_test("reset");
        repeat (reset_cycles)
        begin
            @(posedge clock);
            #1;
            check_idle();
        end
        @(negedge clock);
        reset = 1'b0;
        run_cycle('0, '0, '1);  // first cycle out of reset
        end_test();

        begin_test("self");
        for (int s = 0; s < num_nodes; s++)
        begin
            dests = '0;
            dests[2*s +: 2] = 2'(s);
            run_cycle(4'(1 << s), dests, '1);
            free = '1;
            free[s*paths_per_node] = 1'b0;  // self path busy
            run_cycle(4'(1 << s), dests, free);
        end
        end_test();

        begin_test("adjacent");
        for (int s = 0; s < num_nodes; s++)
        begin
            test_route_cases(s, ring_step(s, 1'b1));
            test_route_cases(s, ring_step(s, 1'b0));
        end
        end_test();

        begin_test("diagonal");
        for (int s = 0; s < num_nodes; s++)
        begin
            test_route_cases(s, ring_step(ring_step(s, 1'b1), 1'b1));
        end
        end_test();

        begin_test("concurrent");
        repeat (random_cycles)
        begin
            run_cycle(4'($urandom), 8'($urandom), 28'($urandom));
        end
        end_test();

        // selects hold, enables drop
        begin_test("hold");
        repeat (8)
        begin
            run_cycle('0, 8'($urandom), 28'($urandom));
        end
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests_run, total_checks, total_errors);
        if (total_errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mesh_setup_master.sv */
//####################################################################
// mesh setup master
// four route selectors feeding one commit stage
//####################################################################

`timescale 1ns/100ps
`default_nettype none

module mesh_setup_master
    import mesh_setup_pkg::*;
(
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic [num_paths-1:0]          path_free,     // 1 = free
    input  wire logic [num_nodes-1:0]          request,
    input  wire node_id_t [num_nodes-1:0]      request_dest,
    output router_ctrl_u [num_nodes-1:0]       router_ctrl,
    output logic [num_nodes-1:0]               response,
    output logic [num_nodes*num_dirs-1:0]      path_block
);

    router_ctrl_u [num_nodes-1:0] proposal [num_nodes];
    logic [num_nodes-1:0]         grant;

    // one selector per processor, seven path bits each
    for (genvar n = 0; n < num_nodes; n++)
    begin : gen_select
        route_select #(
            .source    (node_id_t'(n))
        ) u_select (
            .request   (request[n]),
            .dest      (request_dest[n]),
            .path_free (path_free[n*paths_per_node +: paths_per_node]),
            .proposal  (proposal[n]),
            .grant     (grant[n])
        );
    end

    route_commit u_commit (
        .clock       (clock),
        .reset       (reset),
        .proposal_0  (proposal[0]),
        .proposal_1  (proposal[1]),
        .proposal_2  (proposal[2]),
        .proposal_3  (proposal[3]),
        .grant       (grant),
        .router_ctrl (router_ctrl),
        .response    (response),
        .path_block  (path_block)
    );

endmodule

`default_nettype wire

/* rtl/route_commit.sv */
//####################################################################
// route commit
// merges the four route proposals in processor order, registers
// router controls and grants, and flags blocked edges
//####################################################################

`timescale 1ns/100ps
`default_nettype none

module route_commit
    import mesh_setup_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire router_ctrl_u [num_nodes-1:0]      proposal_0,
    input  wire router_ctrl_u [num_nodes-1:0]      proposal_1,
    input  wire router_ctrl_u [num_nodes-1:0]      proposal_2,
    input  wire router_ctrl_u [num_nodes-1:0]      proposal_3,
    input  wire logic [num_nodes-1:0]              grant,
    output router_ctrl_u [num_nodes-1:0]           router_ctrl,
    output logic [num_nodes-1:0]                   response,
    output logic [num_nodes*num_dirs-1:0]          path_block  // 1 = edge not enabled
);

    router_ctrl_u [num_nodes-1:0] proposals [num_nodes];  // by processor
    router_ctrl_u [num_nodes-1:0] ctrl_next;

    assign proposals[0] = proposal_0;
    assign proposals[1] = proposal_1;
    assign proposals[2] = proposal_2;
    assign proposals[3] = proposal_3;

    // later processors win on a shared edge, enables accumulate
    always_comb
    begin
        for (int r = 0; r < num_nodes; r++)
        begin
            ctrl_next[r].raw       = router_ctrl[r].raw;  // selects hold
            ctrl_next[r].fields.en = '0;
        end
        for (int p = 0; p < num_nodes; p++)
        begin
            for (int r = 0; r < num_nodes; r++)
            begin
                for (int d = 0; d < num_dirs; d++)
                begin
                    if (proposals[p][r].fields.en[d])
                    begin
                        ctrl_next[r].fields.sel[d] = proposals[p][r].fields.sel[d];
                        ctrl_next[r].fields.en[d]  = 1'b1;
                    end
                end
            end
        end
    end

    // one cycle from request to response
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            router_ctrl <= '0;
            response    <= '0;
        end
        else
        begin
            router_ctrl <= ctrl_next;
            response    <= grant;
        end
    end

    // valid ahead of the edge with router 3 in the top bits
    for (genvar r = 0; r < num_nodes; r++)
    begin : gen_block
        assign path_block[r*num_dirs +: num_dirs] = ~ctrl_next[r].fields.en;
    end

endmodule

`default_nettype wire

/* rtl/route_select.sv */
//####################################################################
// route select for one source processor
// picks primary or alternate ring route and walks it to build
// proposed select and enable settings for all four routers
//####################################################################

`timescale 1ns/100ps
`default_nettype none

module route_select
    import mesh_setup_pkg::*;
#(
    parameter node_id_t source = 2'd0
)
(
    input  wire logic                      request,
    input  wire node_id_t                  dest,
    input  wire logic [paths_per_node-1:0] path_free,  // slot 0 self
    output router_ctrl_u [num_nodes-1:0]   proposal,
    output logic                           grant
);

    logic       is_self;
    logic       adjacent_cw;
    logic       adjacent_ccw;
    logic       primary_cw;     // primary route goes clockwise
    node_id_t   dest_rank;      // position among the other three nodes
    logic [2:0] primary_slot;
    logic [2:0] alt_slot;
    logic       route_ok;
    logic       walk_cw;
    node_id_t   node;           // router reached during the walk
    logic       arrived;

    function automatic node_id_t step_node(input node_id_t n, input logic cw);
        return cw ? cw_next[n] : ccw_next[n];
    endfunction

    function automatic logic [2:0] exit_edge(input node_id_t n, input logic cw);
        return cw ? cw_out_dir[n] : ccw_out_dir[n];
    endfunction

    function automatic logic [sel_width-1:0] entry_sel(input node_id_t n, input logic cw);
        return cw ? cw_in_sel[n] : ccw_in_sel[n];
    endfunction

    // write one select field and raise its enable
    function automatic router_ctrl_u set_edge(
        input router_ctrl_u         word,
        input logic [2:0]           edge_idx,
        input logic [sel_width-1:0] sel
    );
        router_ctrl_u result;
        result = word;
        result.fields.sel[edge_idx] = sel;
        result.fields.en[edge_idx]  = 1'b1;
        return result;
    endfunction

    assign is_self      = (dest == source);
    assign adjacent_cw  = (dest == cw_next[source]);
    assign adjacent_ccw = (dest == ccw_next[source]);

    // direct link when adjacent, else parity of the source
    assign primary_cw = adjacent_cw ? 1'b1 :
                        adjacent_ccw ? 1'b0 :
                        !source[0];

    // other destinations in ascending order, two slots each
    assign dest_rank    = (dest < source) ? dest : node_id_t'(dest - 2'd1);
    assign primary_slot = {dest_rank, 1'b1};
    assign alt_slot     = primary_slot + 3'd1;

    always_comb
    begin
        route_ok = 1'b0;
        walk_cw  = primary_cw;
        if (is_self)
        begin
            route_ok = path_free[0];  // only one route to itself
        end
        else if (path_free[primary_slot])
        begin
            route_ok = 1'b1;
        end
        else if (path_free[alt_slot])
        begin
            route_ok = 1'b1;
            walk_cw  = !primary_cw;   // other way round
        end
    end

    // walk the ring from source to dest
    always_comb
    begin
        proposal = '0;
        grant    = 1'b0;
        node     = source;
        arrived  = 1'b0;
        if (request && route_ok)
        begin
            grant = 1'b1;
            if (is_self)
            begin
                proposal[source] = set_edge(proposal[source], dir_proc, sel_from_proc);
            end
            else
            begin
                // source router takes data from its processor
                proposal[source] = set_edge(proposal[source],
                                            exit_edge(source, walk_cw),
                                            sel_from_proc);
                node = step_node(source, walk_cw);

                // at most two routers in between
                for (int hop = 0; hop < num_nodes - 1; hop++)
                begin
                    if (node == dest)
                    begin
                        arrived = 1'b1;
                    end
                    if (!arrived)
                    begin
                        proposal[node] = set_edge(proposal[node],
                                                  exit_edge(node, walk_cw),
                                                  entry_sel(node, walk_cw));
                        node = step_node(node, walk_cw);
                    end
                end

                // hand over to the destination processor
                proposal[dest] = set_edge(proposal[dest], dir_proc,
                                          entry_sel(dest, walk_cw));
            end
        end
    end

endmodule

`default_nettype wire

/* common/mesh_setup_pkg.sv */
//####################################################################
// mesh setup package
// sizes, direction codes, ring tables and router control word
// for the 2x2 mesh path-setup master
//####################################################################

`default_nettype none

package mesh_setup_pkg;

    localparam int num_nodes      = 4;   // routers and processors
    localparam int num_dirs       = 5;   // n, s, e, w, processor
    localparam int sel_width      = 3;
    localparam int paths_per_node = 7;
    localparam int num_paths      = num_nodes * paths_per_node;

    typedef logic [1:0] node_id_t;

    // edge index, also enable bit and select slot
    localparam logic [2:0] dir_north = 3'd4;
    localparam logic [2:0] dir_south = 3'd3;
    localparam logic [2:0] dir_east  = 3'd2;
    localparam logic [2:0] dir_west  = 3'd1;
    localparam logic [2:0] dir_proc  = 3'd0;

    // input edge feeding an output edge
    localparam logic [sel_width-1:0] sel_from_north = 3'b000;
    localparam logic [sel_width-1:0] sel_from_south = 3'b001;
    localparam logic [sel_width-1:0] sel_from_east  = 3'b010;
    localparam logic [sel_width-1:0] sel_from_west  = 3'b011;
    localparam logic [sel_width-1:0] sel_from_proc  = 3'b100;

    // clockwise ring is r0 -> r2 -> r3 -> r1 -> r0
    // r2 r3 on top, r0 r1 below
    localparam node_id_t cw_next [num_nodes] = '{2'd2, 2'd0, 2'd3, 2'd1};
    localparam node_id_t ccw_next [num_nodes] = '{2'd1, 2'd3, 2'd0, 2'd2};

    // edge leaving towards the neighbour
    localparam logic [2:0] cw_out_dir [num_nodes] = '{
        dir_north,   // r0 up to r2
        dir_west,    // r1 left to r0
        dir_east,    // r2 right to r3
        dir_south    // r3 down to r1
    };
    localparam logic [2:0] ccw_out_dir [num_nodes] = '{
        dir_east,
        dir_north,
        dir_south,
        dir_west
    };

    // edge on which traffic arrives going that way round
    localparam logic [sel_width-1:0] cw_in_sel [num_nodes] = '{
        sel_from_east,
        sel_from_north,
        sel_from_south,
        sel_from_west
    };
    localparam logic [sel_width-1:0] ccw_in_sel [num_nodes] = '{
        sel_from_north,
        sel_from_west,
        sel_from_east,
        sel_from_south
    };

    // one router's control word, flat or split
    // enables also act as write mask of a proposal
    typedef union packed {
        logic [num_dirs*(sel_width+1)-1:0] raw;
        struct packed {
            logic [num_dirs-1:0][sel_width-1:0] sel;  // north in msbs
            logic [num_dirs-1:0]                en;
        } fields;
    } router_ctrl_u;

endpackage

`default_nettype wire
